/* rtl/decodePkg.sv */
// decode stage package with widths, RV32I opcodes and the shared stage structs
`default_nettype none

package decodePkg;

    localparam int dataWidth    = 32;                   // register and address width
    localparam int regAddrWidth = 5;                    // x0..x31

    // base opcodes of the supported RV32I classes
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;

    typedef enum logic [2:0] {
        immI,                                           // loads, op-imm, jalr
        immS,
        immB,
        immU,
        immJ
    } immKindE;

    typedef struct packed {
        logic regWrite;
        logic memToReg;                                 // load result to rd
        logic memRead;
        logic memWrite;
        logic aluSrc;                                   // imm as second operand
        logic branch;
        logic jump;
        logic jalr;                                     // target base is rs1
        logic pcBase;                                   // pc as first operand
    } ctrlT;

    typedef struct packed {
        logic                    enable;
        logic [regAddrWidth-1:0] addr;
        logic [dataWidth-1:0]    data;
    } writebackT;

    typedef struct packed {
        logic                 taken;
        logic [dataWidth-1:0] target;
    } redirectT;

    typedef struct packed {
        logic                    valid;
        logic [dataWidth-1:0]    pc;
        logic [dataWidth-1:0]    rs1Data;
        logic [dataWidth-1:0]    rs2Data;
        logic [dataWidth-1:0]    imm;
        logic [regAddrWidth-1:0] rd;
        logic [2:0]              funct3;
        logic                    funct7b5;              // sub / sra select
        ctrlT                    ctrl;
    } idExT;

endpackage

`default_nettype wire

/* rtl/controlDecoder.sv */
// main control decoder, opcode to control bits and immediate format
`timescale 1ns/100ps
`default_nettype none

module controlDecoder (
    input  logic [decodePkg::dataWidth-1:0] instr,
    input  logic                            instrValid,
    output decodePkg::ctrlT                 ctrl,
    output decodePkg::immKindE              immKind
);
    import decodePkg::*;

    logic [6:0] opcode;

    assign opcode = instr[6:0];

    always_comb begin
        ctrl    = '0;                                   // bubble unless recognised
        immKind = immI;
        if (instrValid) begin
            case (opcode)
                opLui: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    immKind       = immU;
                end
                opAuipc: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.pcBase   = 1'b1;               // pc + upper imm
                    immKind       = immU;
                end
                opJal: begin
                    ctrl.regWrite = 1'b1;               // link to rd
                    ctrl.jump     = 1'b1;
                    ctrl.pcBase   = 1'b1;
                    immKind       = immJ;
                end
                opJalr: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.jump     = 1'b1;
                    ctrl.jalr     = 1'b1;
                    immKind       = immI;
                end
                opBranch: begin
                    ctrl.branch = 1'b1;
                    immKind     = immB;
                end
                opLoad: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.memToReg = 1'b1;
                    ctrl.memRead  = 1'b1;
                    ctrl.aluSrc   = 1'b1;               // base + offset
                    immKind       = immI;
                end
                opStore: begin
                    ctrl.memWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    immKind       = immS;
                end
                opOpImm: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    immKind       = immI;
                end
                opOp: ctrl.regWrite = 1'b1;             // reg-reg alu
                default: ;                              // unknown, stays a bubble
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/immediateGen.sv */
// immediate generator, sign-extended I/S/B/U/J immediates from the instruction
`timescale 1ns/100ps
`default_nettype none

module immediateGen (
    input  logic [decodePkg::dataWidth-1:0] instr,
    input  decodePkg::immKindE              immKind,
    output logic [decodePkg::dataWidth-1:0] imm
);
    import decodePkg::*;

    logic sign;

    assign sign = instr[31];                            // always the imm msb

    always_comb begin
        case (immKind)
            immI: imm = {{20{sign}}, instr[31:20]};
            immS: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            immB: begin
                // bit 11 sits in instr[7], lsb implied zero
                imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            immU: imm = {instr[31:12], 12'b0};          // upper 20, zeros below
            immJ: begin
                // 20 | 10:1 | 11 | 19:12 in instruction order
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/registerFile.sv */
// integer register file, 2 async reads, 1 sync write with write-to-read bypass
`timescale 1ns/100ps
`default_nettype none

module registerFile (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [decodePkg::regAddrWidth-1:0] rs1Addr,
    input  logic [decodePkg::regAddrWidth-1:0] rs2Addr,
    input  decodePkg::writebackT               writeback,
    output logic [decodePkg::dataWidth-1:0]    rs1Data,
    output logic [decodePkg::dataWidth-1:0]    rs2Data
);
    import decodePkg::*;

    logic [dataWidth-1:0] regs [1:31];                  // x0 has no storage
    logic                 wrEn;

    assign wrEn = writeback.enable && (writeback.addr != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[writeback.addr] <= writeback.data;
        end
    end

    always_comb begin
        if (rs1Addr == '0)
            rs1Data = '0;                               // x0 hardwired
        else if (wrEn && (rs1Addr == writeback.addr))
            rs1Data = writeback.data;                   // same-cycle bypass
        else
            rs1Data = regs[rs1Addr];
    end

    always_comb begin
        if (rs2Addr == '0)
            rs2Data = '0;
        else if (wrEn && (rs2Addr == writeback.addr))
            rs2Data = writeback.data;
        else
            rs2Data = regs[rs2Addr];
    end

endmodule

`default_nettype wire

/* rtl/branchUnit.sv */
// branch resolution in decode, condition compare and redirect target adder
`timescale 1ns/100ps
`default_nettype none

module branchUnit (
    input  logic [decodePkg::dataWidth-1:0] pc,
    input  logic [decodePkg::dataWidth-1:0] rs1Data,
    input  logic [decodePkg::dataWidth-1:0] rs2Data,
    input  logic [decodePkg::dataWidth-1:0] imm,
    input  logic [2:0]                      funct3,
    input  decodePkg::ctrlT                 ctrl,
    output decodePkg::redirectT             redirect
);
    import decodePkg::*;

    logic [dataWidth:0]   diff;                         // extra bit is the borrow
    logic                 isEqual;
    logic                 ltSigned;
    logic                 ltUnsigned;
    logic                 condMet;
    logic [dataWidth-1:0] base;
    logic [dataWidth-1:0] sum;

    // single subtractor shared by all compares
    assign diff       = {1'b0, rs1Data} - {1'b0, rs2Data};
    assign isEqual    = (diff[dataWidth-1:0] == '0);
    assign ltUnsigned = diff[dataWidth];                // borrow out
    // signs differ -> rs1 sign decides, else the difference sign
    assign ltSigned   = (rs1Data[dataWidth-1] ^ rs2Data[dataWidth-1]) ?
                        rs1Data[dataWidth-1] : diff[dataWidth-1];

    always_comb begin
        case (funct3)
            3'd0:    condMet = isEqual;                 // beq
            3'd1:    condMet = !isEqual;                // bne
            3'd4:    condMet = ltSigned;                // blt
            3'd5:    condMet = !ltSigned;               // bge
            3'd6:    condMet = ltUnsigned;              // bltu
            3'd7:    condMet = !ltUnsigned;             // bgeu
            default: condMet = 1'b0;                    // 2, 3 reserved
        endcase
    end

    assign base = ctrl.jalr ? rs1Data : pc;
    assign sum  = base + imm;

    assign redirect.taken  = ctrl.jump || (ctrl.branch && condMet);
    assign redirect.target = {sum[dataWidth-1:1], sum[0] & ~ctrl.jalr};   // jalr clears lsb

endmodule

`default_nettype wire

/* rtl/decodeStage.sv */
// RV32I decode stage, control, immediates, regfile, branch redirect and id/ex register
`timescale 1ns/100ps
`default_nettype none

module decodeStage (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            instrValid,
    input  logic [decodePkg::dataWidth-1:0] instr,
    input  logic [decodePkg::dataWidth-1:0] pc,
    input  logic                            stall,
    input  decodePkg::writebackT            writeback,
    output decodePkg::redirectT             redirect,
    output decodePkg::idExT                 idEx
);
    import decodePkg::*;

    ctrlT                    ctrl;
    immKindE                 immKind;
    logic [dataWidth-1:0]    imm;
    logic [dataWidth-1:0]    rs1Data;
    logic [dataWidth-1:0]    rs2Data;
    logic [regAddrWidth-1:0] rs1Addr;
    logic [regAddrWidth-1:0] rs2Addr;
    logic [2:0]              funct3;
    idExT                    idExNext;

    // fixed RV32I field positions
    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];
    assign funct3  = instr[14:12];

    controlDecoder ctrlDec (
        .instr      (instr),
        .instrValid (instrValid),
        .ctrl       (ctrl),
        .immKind    (immKind)
    );

    immediateGen immGen (
        .instr   (instr),
        .immKind (immKind),
        .imm     (imm)
    );

    registerFile regFile (
        .clk       (clk),
        .reset     (reset),
        .rs1Addr   (rs1Addr),
        .rs2Addr   (rs2Addr),
        .writeback (writeback),                         // from end of pipe
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data)
    );

    branchUnit brUnit (
        .pc       (pc),
        .rs1Data  (rs1Data),
        .rs2Data  (rs2Data),
        .imm      (imm),
        .funct3   (funct3),
        .ctrl     (ctrl),
        .redirect (redirect)                            // same-cycle to fetch
    );

    always_comb begin
        idExNext          = '0;
        idExNext.valid    = instrValid;
        idExNext.pc       = pc;
        idExNext.rs1Data  = rs1Data;
        idExNext.rs2Data  = rs2Data;
        idExNext.imm      = imm;
        idExNext.rd       = instr[11:7];
        idExNext.funct3   = funct3;
        idExNext.funct7b5 = instr[30];
        idExNext.ctrl     = ctrl;                       // zero when invalid
    end

    always_ff @(posedge clk) begin
        if (reset)
            idEx <= '0;
        else if (!stall)
            idEx <= idExNext;                           // hold while stalled
    end

endmodule

`default_nettype wire

/* test/decodeVectors.svh */
// decode stage test vectors, writeback setup, instructions and expected results
`ifndef decodeVectorsSvh
`define decodeVectorsSvh

task automatic buildTable();
    logic [31:0] valA;
    logic [31:0] bpc;
    logic [31:0] off;
    int          rs1;
    int          rs2;
    logic        tk;
    valA = $random(seed);                                   // x1 and x3 share it
    addRow("readZero", '0, encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd7), 32'h100, 0, 1, '0, 0, ctrlOp);
    addRow("bypassX1", {1'b1, 5'd1, valA}, encR(7'h00, 5'd0, 5'd1, 3'd0, 5'd8), 32'h104,
           0, 1, '0, 0, ctrlOp);
    addRow("bypassX2", {1'b1, 5'd2, $random(seed)}, encR(7'h20, 5'd2, 5'd1, 3'd0, 5'd9),
           32'h108, 0, 1, '0, 0, ctrlOp);
    addRow("opImm", {1'b1, 5'd3, valA}, encI(32'hFFFFFFFB, 5'd3, 3'd0, 5'd10, opOpImm),
           32'h10C, 0, 1, '0, 32'hFFFFFFFB, ctrlOpImm);
    addRow("lui", {1'b1, 5'd4, $random(seed) | 32'h80000000}, encU(20'hABC00, 5'd11, opLui),
           32'h110, 0, 1, '0, 32'hABC00000, ctrlLui);   // x4 negative
    addRow("auipc", {1'b1, 5'd5, $random(seed) & 32'h7FFFFFFF}, encU(20'h1, 5'd12, opAuipc),
           32'h2000, 0, 1, '0, 32'h1000, ctrlAuipc);    // x5 positive
    addRow("load", {1'b1, 5'd6, $random(seed) | 32'h1}, encI(32'h7F0, 5'd6, 3'd2, 5'd13, opLoad),
           32'h2004, 0, 1, '0, 32'h7F0, ctrlLoad);      // odd jalr base
    addRow("store", {1'b1, 5'd0, 32'hDEADBEEF}, encS(32'hFFFFFFF8, 5'd2, 5'd0, 3'd2),
           32'h2008, 0, 1, '0, 32'hFFFFFFF8, ctrlStore);
    addRow("x0Read", '0, encR(7'h00, 5'd1, 5'd0, 3'd0, 5'd14), 32'h200C, 0, 1, '0, 0, ctrlOp);
    addRow("unknown", '0, 32'h0000007F, 32'h2010, 0, 1, '0, 0, '0);
    // pairs: x1==x3, x4<x5 signed only, x5<x4 unsigned only
    for (int f3 = 0; f3 < 8; f3++) begin
        for (int p = 0; p < 3; p++) begin
            rs1 = (p == 0) ? 1 : (p == 1) ? 4 : 5;
            rs2 = (p == 0) ? 3 : (p == 1) ? 5 : 4;
            case (f3)
                0:       tk = (p == 0);
                1:       tk = (p != 0);
                4:       tk = (p == 1);
                5:       tk = (p != 1);
                6:       tk = (p == 2);
                7:       tk = (p != 2);
                default: tk = 1'b0;                         // 2 and 3 never branch
            endcase
            off = (p == 1) ? 32'hFFFFFFE0 : 32'h00000040;
            bpc = 32'h1000 + (f3 << 8) + (p << 4);
            addRow($sformatf("branchF%0dP%0d", f3, p), '0, encB(off, rs2[4:0], rs1[4:0], f3[2:0]),
                   bpc, 0, 1, {tk, bpc + off}, off, ctrlBr);
        end
    end
    addRow("jal", '0, encJ(32'h00012344, 5'd15), 32'h3000, 0, 1, {1'b1, 32'h00015344},
           32'h00012344, ctrlJal);
    addRow("jalr", '0, encI(32'hFFFFFFF6, 5'd6, 3'd0, 5'd16, opJalr), 32'h3100, 0, 1,
           {1'b1, (regModel[6] + 32'hFFFFFFF6) & 32'hFFFFFFFE}, 32'hFFFFFFF6, ctrlJalr);
    addRow("stall", '0, encB(32'h40, 5'd3, 5'd1, 3'd0), 32'h4000, 1, 1, {1'b1, 32'h4040},
           32'h40, ctrlBr);
    addRow("invalid", '0, encJ(32'h100, 5'd1), 32'h5000, 0, 0, '0, 32'h100, ctrlJal);
endtask

`endif

/* test/decodeTb.sv */
// testbench for the RV32I decode stage, table driven redirect and id/ex checks
`timescale 1ns/100ps
`default_nettype none

module decodeTb;
    import decodePkg::*;

    typedef struct {
        string       name;
        writebackT   wb;
        logic [31:0] instr;
        logic [31:0] pc;
        logic        stall;
        logic        valid;
        redirectT    expRedirect;
        idExT        expIdEx;
    } rowT;

    // regWrite memToReg memRead memWrite aluSrc branch jump jalr pcBase
    localparam ctrlT ctrlLui   = 9'b100010000;
    localparam ctrlT ctrlAuipc = 9'b100010001;
    localparam ctrlT ctrlJal   = 9'b100000101;
    localparam ctrlT ctrlJalr  = 9'b100010110;
    localparam ctrlT ctrlBr    = 9'b000001000;
    localparam ctrlT ctrlLoad  = 9'b111010000;
    localparam ctrlT ctrlStore = 9'b000110000;
    localparam ctrlT ctrlOpImm = 9'b100010000;
    localparam ctrlT ctrlOp    = 9'b100000000;

    logic        clk = 1'b0;
    logic        reset;
    logic        instrValid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        stall;
    writebackT   writeback;
    redirectT    redirect;
    idExT        idEx;
    rowT         vectors[$];
    logic [31:0] regModel [0:31];                           // expected register contents
    idExT        lastIdEx;
    integer      seed = 32'ha065;
    int          cycles = 0;
    int          cycleLimit = 40;
    int          passCount = 0;
    int          failCount = 0;

    decodeStage dut_i (
        .clk        (clk),
        .reset      (reset),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .stall      (stall),
        .writeback  (writeback),
        .redirect   (redirect),
        .idEx       (idEx)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout, the run did not finish within %0d cycles", cycleLimit);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opOp};
    endfunction

    function automatic logic [31:0] encI(input logic [31:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [31:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] encB(input logic [31:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] upper, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {upper, rd, op};
    endfunction

    function automatic logic [31:0] encJ(input logic [31:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    task automatic addRow(input string name, input writebackT wb, input logic [31:0] instrW,
                          input logic [31:0] pcW, input logic stallW, input logic validW,
                          input redirectT expRedir, input logic [31:0] immW, input ctrlT ctrlW);
        rowT  r;
        idExT e;
        if (wb.enable && wb.addr != 5'd0)
            regModel[wb.addr] = wb.data;                    // seen by this row via bypass
        e          = '0;
        e.valid    = validW;
        e.pc       = pcW;
        e.rs1Data  = regModel[instrW[19:15]];
        e.rs2Data  = regModel[instrW[24:20]];
        e.imm      = immW;
        e.rd       = instrW[11:7];
        e.funct3   = instrW[14:12];
        e.funct7b5 = instrW[30];
        e.ctrl     = validW ? ctrlW : '0;
        if (stallW)
            e = lastIdEx;                                   // id/ex holds
        lastIdEx      = e;
        r.name        = name;
        r.wb          = wb;
        r.instr       = instrW;
        r.pc          = pcW;
        r.stall       = stallW;
        r.valid       = validW;
        r.expRedirect = expRedir;
        r.expIdEx     = e;
        vectors.push_back(r);
    endtask

    task automatic checkRedirect(input string name, input redirectT exp, input redirectT act);
        logic ok;
        ok = exp.taken ? (act === exp) : (act.taken === 1'b0);   // target free when not taken
        if (ok) begin
            passCount++;
            $display("ok       %s redirect", name);
        end else begin
            failCount++;
            $display("mismatch %s redirect expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic checkIdEx(input string name, input idExT exp, input idExT act);
        idExT want;
        logic ok;
        want = exp;
        if (!exp.ctrl.aluSrc && !exp.ctrl.branch && !exp.ctrl.jump)
            want.imm = act.imm;                             // r-type has no immediate
        if (exp.valid)
            ok = (act === want);
        else
            ok = (act.valid === 1'b0) && (act.ctrl === '0);   // bubble
        if (ok) begin
            passCount++;
            $display("ok       %s idEx", name);
        end else begin
            failCount++;
            $display("mismatch %s idEx expected %h actual %h", name, want, act);
        end
    endtask

    `include "decodeVectors.svh"

    initial begin
        reset      = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        stall      = 1'b0;
        writeback  = '0;
        lastIdEx   = '0;
        foreach (regModel[i])
            regModel[i] = '0;
        buildTable();
        cycleLimit = 4 * vectors.size() + 40;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkRedirect("reset", '0, redirect);
        checkIdEx("reset", '0, idEx);
        foreach (vectors[i]) begin
            @(posedge clk);
            writeback  <= vectors[i].wb;
            instr      <= vectors[i].instr;
            pc         <= vectors[i].pc;
            stall      <= vectors[i].stall;
            instrValid <= vectors[i].valid;
            @(negedge clk);
            checkRedirect(vectors[i].name, vectors[i].expRedirect, redirect);
            @(negedge clk);                                 // one edge later
            checkIdEx(vectors[i].name, vectors[i].expIdEx, idEx);
        end
        $display("checks passed %0d failed %0d", passCount, failCount);
        if (failCount == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+test
rtl/decodePkg.sv
rtl/controlDecoder.sv
rtl/immediateGen.sv
rtl/registerFile.sv
rtl/branchUnit.sv
rtl/decodeStage.sv
test/decodeTb.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - files:
      - rtl/decodePkg.sv
      - rtl/controlDecoder.sv
      - rtl/immediateGen.sv
      - rtl/registerFile.sv
      - rtl/branchUnit.sv
      - rtl/decodeStage.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/decodeTb.sv
